// ==== build.f ====
design/board_pkg.sv
design/pps_tracker.sv
design/flash_reader.sv
design/lcd_nibble_writer.sv
design/board_core.sv
design/fpga_top.sv
tb/tb_fpga_top.sv

// ==== design/board_core.sv ====
// Board subsystem core
// HSMC-triggered flash reads echoed to HSMC, LEDs and LCD, plus PPS regeneration
`timescale 1ns/10ps
module board_core #(
  parameter int FLASH_ACCESS_CYCLES = board_pkg::FLASH_ACCESS_CYCLES_DEF,
  parameter int LCD_E_CYCLES        = board_pkg::LCD_E_CYCLES_DEF,
  parameter int PPS_OUT_CYCLES      = board_pkg::PPS_OUT_CYCLES_DEF
) (
  input  logic                   sys0_clk,
  input  logic                   rst_n,
  input  logic [7:0]             usr_sw,        // Bit 0 LED select, bit 6 LCD rs
  output logic [15:0]            led,
  input  logic [15:0]            hsmc_in,       // Bit 15 trigger, 14:0 address
  output logic [15:0]            hsmc_out,      // Last flash word
  input  logic                   pps_in,
  output logic                   pps_out,
  output board_pkg::flash_addr_t flash_addr,
  input  board_pkg::flash_data_t flash_dq_in,
  output logic                   flash_dq_oe,
  output logic                   flash_ce_n,
  output logic                   flash_oe_n,
  output logic                   flash_we_n,
  input  logic                   flash_rdy,
  output board_pkg::lcd_nibble_t lcd_db,
  output logic                   lcd_e,
  output logic                   lcd_rs,
  output logic                   lcd_rw
);
  import board_pkg::*;

  logic [1:0]  trig_sync;     // Trigger synchronizer
  logic        trig_last;
  logic        trig_rise;
  logic        read_start;
  logic        read_done;
  logic        rd_busy;
  flash_addr_t read_addr;
  flash_data_t read_data;
  logic        wr_start;
  logic        wr_rs;
  logic [7:0]  wr_byte;
  logic        lcd_busy;
  logic        lcd_free;      // Writer can take a strobe this cycle
  logic        q_valid;       // One-byte LCD queue
  logic [7:0]  q_byte;
  logic        direct_wr;     // New byte straight to the writer
  logic        queue_wr;      // New byte parked in the queue
  logic        drain;         // Queued byte to the writer
  logic        pps_seen;
  pps_period_t pps_period;
  logic [15:0] pps_word;      // Period shown on the LEDs

  assign trig_rise  = trig_sync[1] & ~trig_last;
  assign lcd_free   = ~lcd_busy & ~wr_start;
  assign direct_wr  = read_done & lcd_free & ~q_valid;
  assign queue_wr   = read_done & ~direct_wr;              // Newest byte wins
  assign drain      = ~read_done & q_valid & lcd_free;
  assign flash_we_n = 1'b1;
  assign lcd_rw     = 1'b0;

  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      trig_sync  <= '0;
      trig_last  <= 1'b0;
      read_start <= 1'b0;
      wr_start   <= 1'b0;
      q_valid    <= 1'b0;
      hsmc_out   <= '0;
      pps_word   <= '0;
      led        <= '0;
    end else begin
      trig_sync  <= {trig_sync[0], hsmc_in[15]};
      trig_last  <= trig_sync[1];
      read_start <= trig_rise & ~rd_busy;                  // Busy reader drops it
      wr_start   <= direct_wr | drain;
      if (queue_wr) begin
        q_valid <= 1'b1;
      end else if (drain) begin
        q_valid <= 1'b0;
      end
      if (read_done) begin
        hsmc_out <= read_data;
      end
      if (pps_seen) begin
        pps_word <= pps_period[15:0];
      end
      led <= usr_sw[0] ? hsmc_out : pps_word;
    end
  end

  // Read address and LCD byte path
  always_ff @(posedge sys0_clk) begin
    if (trig_rise && !rd_busy) begin
      read_addr <= flash_addr_t'(hsmc_in[14:0]);
    end
    if (queue_wr) begin
      q_byte <= read_data[7:0];
    end
    if (direct_wr) begin
      wr_byte <= read_data[7:0];
    end else if (drain) begin
      wr_byte <= q_byte;
    end
    if (direct_wr || drain) begin
      wr_rs <= usr_sw[6];                                  // Sampled at write start
    end
  end

  pps_tracker #(
    .PPS_OUT_CYCLES (PPS_OUT_CYCLES)
  ) u_pps (
    .sys0_clk   (sys0_clk),
    .rst_n      (rst_n),
    .pps_in     (pps_in),
    .pps_out    (pps_out),
    .pps_seen   (pps_seen),
    .pps_period (pps_period)
  );

  flash_reader #(
    .FLASH_ACCESS_CYCLES (FLASH_ACCESS_CYCLES)
  ) u_flash (
    .sys0_clk    (sys0_clk),
    .rst_n       (rst_n),
    .read_start  (read_start),
    .read_addr   (read_addr),
    .read_data   (read_data),
    .read_done   (read_done),
    .busy        (rd_busy),
    .flash_addr  (flash_addr),
    .flash_dq_in (flash_dq_in),
    .flash_dq_oe (flash_dq_oe),
    .flash_ce_n  (flash_ce_n),
    .flash_oe_n  (flash_oe_n),
    .flash_rdy   (flash_rdy)
  );

  lcd_nibble_writer #(
    .LCD_E_CYCLES (LCD_E_CYCLES)
  ) u_lcd (
    .sys0_clk (sys0_clk),
    .rst_n    (rst_n),
    .wr_start (wr_start),
    .wr_byte  (wr_byte),
    .wr_rs    (wr_rs),
    .busy     (lcd_busy),
    .lcd_db   (lcd_db),
    .lcd_e    (lcd_e),
    .lcd_rs   (lcd_rs)
  );

  // Strobes land only on idle units
  a_no_busy_strobe: assert property (@(posedge sys0_clk) disable iff (!rst_n)
    (read_start |-> !rd_busy) and (wr_start |-> !lcd_busy));

endmodule

// ==== design/board_pkg.sv ====
// Board subsystem shared definitions
// Bus widths, FSM encodings and default timing constants
package board_pkg;

  typedef logic [23:0] flash_addr_t;    // NOR word address
  typedef logic [15:0] flash_data_t;    // NOR data word
  typedef logic [31:0] pps_period_t;    // Edge to edge count in sys0_clk cycles
  typedef logic [3:0]  lcd_nibble_t;    // LCD data bus in 4-bit mode

  // Flash read sequence
  typedef enum logic [2:0] {
    FS_IDLE,
    FS_SETUP,       // Address out, chip enabled
    FS_ACCESS,      // Output enable low for the access time
    FS_WAIT_RDY,    // Wait for the ready pin
    FS_RECOVER      // Enables high before the next cycle
  } flash_state_t;

  // LCD byte transfer as two nibbles
  typedef enum logic [2:0] {
    LS_IDLE,
    LS_HI_SETUP,
    LS_HI_PULSE,
    LS_LO_SETUP,
    LS_LO_PULSE,
    LS_GAP          // Execution time after the byte
  } lcd_state_t;

  localparam int FLASH_ACCESS_CYCLES_DEF = 4;   // Min oe_n low before ready wait
  localparam int LCD_E_CYCLES_DEF        = 6;   // Enable pulse width
  localparam int PPS_OUT_CYCLES_DEF      = 8;   // Regenerated PPS width

endpackage

// ==== design/flash_reader.sv ====
// NOR flash reader
// Runs one asynchronous read cycle per strobe and waits on the ready pin
`timescale 1ns/10ps
module flash_reader #(
  parameter int FLASH_ACCESS_CYCLES = board_pkg::FLASH_ACCESS_CYCLES_DEF
) (
  input  logic                   sys0_clk,
  input  logic                   rst_n,
  input  logic                   read_start,    // Accepted only when idle
  input  board_pkg::flash_addr_t read_addr,
  output board_pkg::flash_data_t read_data,     // Valid with read_done
  output logic                   read_done,     // One cycle pulse
  output logic                   busy,
  output board_pkg::flash_addr_t flash_addr,
  input  board_pkg::flash_data_t flash_dq_in,
  output logic                   flash_dq_oe,
  output logic                   flash_ce_n,
  output logic                   flash_oe_n,
  input  logic                   flash_rdy      // High when data is ready
);
  import board_pkg::*;

  localparam int CNT_W = $clog2(FLASH_ACCESS_CYCLES + 1);

  flash_state_t     state;
  logic [CNT_W-1:0] acc_cnt;    // Access cycles left

  assign busy        = (state != FS_IDLE);
  assign flash_dq_oe = 1'b0;    // Read only, bus never driven

  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= FS_IDLE;
      acc_cnt    <= '0;
      flash_ce_n <= 1'b1;
      flash_oe_n <= 1'b1;
      read_done  <= 1'b0;
    end else begin
      read_done <= 1'b0;
      case (state)
        FS_IDLE: begin
          if (read_start) begin
            flash_ce_n <= 1'b0;                  // Chip on with the address
            state      <= FS_SETUP;
          end
        end
        FS_SETUP: begin
          flash_oe_n <= 1'b0;
          acc_cnt    <= CNT_W'(FLASH_ACCESS_CYCLES - 1);
          state      <= FS_ACCESS;
        end
        FS_ACCESS: begin
          if (acc_cnt == '0) begin
            state <= FS_WAIT_RDY;
          end else begin
            acc_cnt <= acc_cnt - 1'b1;
          end
        end
        FS_WAIT_RDY: begin
          if (flash_rdy) begin
            flash_ce_n <= 1'b1;                  // Data captured this edge
            flash_oe_n <= 1'b1;
            state      <= FS_RECOVER;
          end
        end
        FS_RECOVER: begin
          read_done <= 1'b1;
          state     <= FS_IDLE;
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  // Address and data capture
  always_ff @(posedge sys0_clk) begin
    if (state == FS_IDLE && read_start) begin
      flash_addr <= read_addr;
    end
    if (state == FS_WAIT_RDY && flash_rdy) begin
      read_data <= flash_dq_in;
    end
  end

  // Output enable only inside a chip-enabled window
  a_oe_needs_ce: assert property (@(posedge sys0_clk) disable iff (!rst_n)
    !flash_oe_n |-> !flash_ce_n);

endmodule

// ==== design/fpga_top.sv ====
// FPGA evaluation board top
// Maps the board pins onto the subsystem core
`timescale 1ns/10ps
module fpga_top #(
  parameter int FLASH_ACCESS_CYCLES = board_pkg::FLASH_ACCESS_CYCLES_DEF,
  parameter int LCD_E_CYCLES        = board_pkg::LCD_E_CYCLES_DEF,
  parameter int PPS_OUT_CYCLES      = board_pkg::PPS_OUT_CYCLES_DEF
) (
  input  logic        sys0_clk,        // Free-running board clock
  input  logic        rst_n,           // Board reset
  input  logic [7:0]  usr_sw,          // DIP switches
  output logic [15:0] led,
  input  logic [15:0] hsmc_in,         // HSMC inputs
  output logic [15:0] hsmc_out,        // HSMC outputs
  output logic [3:0]  lcd_db,          // LCD data bus
  output logic        lcd_e,
  output logic        lcd_rs,
  output logic        lcd_rw,
  input  logic        ppsExtIn,        // External PPS
  output logic        ppsOut,
  output logic [25:0] fsm_a,           // Shared flash address
  input  logic [15:0] fsm_d_in,        // Flash data from the pads
  output logic [15:0] fsm_d_out,
  output logic        fsm_d_oe,        // Pad driver enable
  output logic        flash_cen,
  output logic        flash_oen,
  output logic        flash_wen,
  input  logic        flash_rdybsyn    // Flash ready
);

  assign fsm_a[25:24] = 2'b00;         // Upper bank unused
  assign fsm_d_out    = '0;            // No flash writes

  board_core #(
    .FLASH_ACCESS_CYCLES (FLASH_ACCESS_CYCLES),
    .LCD_E_CYCLES        (LCD_E_CYCLES),
    .PPS_OUT_CYCLES      (PPS_OUT_CYCLES)
  ) u_core (
    .sys0_clk    (sys0_clk),
    .rst_n       (rst_n),
    .usr_sw      (usr_sw),
    .led         (led),
    .hsmc_in     (hsmc_in),
    .hsmc_out    (hsmc_out),
    .pps_in      (ppsExtIn),
    .pps_out     (ppsOut),
    .flash_addr  (fsm_a[23:0]),
    .flash_dq_in (fsm_d_in),
    .flash_dq_oe (fsm_d_oe),
    .flash_ce_n  (flash_cen),
    .flash_oe_n  (flash_oen),
    .flash_we_n  (flash_wen),
    .flash_rdy   (flash_rdybsyn),
    .lcd_db      (lcd_db),
    .lcd_e       (lcd_e),
    .lcd_rs      (lcd_rs),
    .lcd_rw      (lcd_rw)
  );

endmodule

// ==== design/lcd_nibble_writer.sv ====
// LCD nibble writer
// Sends a byte over the 4-bit LCD bus as two enable-strobed nibbles
`timescale 1ns/10ps
module lcd_nibble_writer #(
  parameter int LCD_E_CYCLES = board_pkg::LCD_E_CYCLES_DEF
) (
  input  logic                   sys0_clk,
  input  logic                   rst_n,
  input  logic                   wr_start,     // Accepted only when idle
  input  logic [7:0]             wr_byte,
  input  logic                   wr_rs,        // Register select for this byte
  output logic                   busy,
  output board_pkg::lcd_nibble_t lcd_db,
  output logic                   lcd_e,
  output logic                   lcd_rs
);
  import board_pkg::*;

  localparam int CNT_W = $clog2(LCD_E_CYCLES + 1);

  lcd_state_t       state;
  logic [CNT_W-1:0] cnt;          // Pulse and gap timer
  lcd_nibble_t      lo_nibble;    // Held for the second transfer

  assign busy = (state != LS_IDLE);

  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= LS_IDLE;
      cnt    <= '0;
      lcd_db <= '0;
      lcd_e  <= 1'b0;
      lcd_rs <= 1'b0;
    end else begin
      case (state)
        LS_IDLE: begin
          if (wr_start) begin
            lcd_db <= wr_byte[7:4];             // High nibble first
            lcd_rs <= wr_rs;
            state  <= LS_HI_SETUP;
          end
        end
        LS_HI_SETUP: begin
          lcd_e <= 1'b1;
          cnt   <= CNT_W'(LCD_E_CYCLES);        // Pulse plus one hold cycle
          state <= LS_HI_PULSE;
        end
        LS_HI_PULSE: begin
          if (cnt == CNT_W'(1)) begin
            lcd_e <= 1'b0;
          end
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            lcd_db <= lo_nibble;                // Bus changes after the hold
            state  <= LS_LO_SETUP;
          end
        end
        LS_LO_SETUP: begin
          lcd_e <= 1'b1;
          cnt   <= CNT_W'(LCD_E_CYCLES);
          state <= LS_LO_PULSE;
        end
        LS_LO_PULSE: begin
          if (cnt == CNT_W'(1)) begin
            lcd_e <= 1'b0;
          end
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            cnt   <= CNT_W'(LCD_E_CYCLES - 1);
            state <= LS_GAP;
          end
        end
        LS_GAP: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end else begin
            state <= LS_IDLE;
          end
        end
        default: state <= LS_IDLE;
      endcase
    end
  end

  always_ff @(posedge sys0_clk) begin
    if (state == LS_IDLE && wr_start) begin
      lo_nibble <= wr_byte[3:0];
    end
  end

  // LCD latches on the falling enable, so the bus must hold for the whole pulse
  a_db_stable: assert property (@(posedge sys0_clk) disable iff (!rst_n)
    lcd_e |-> $stable(lcd_db) && $stable(lcd_rs));

endmodule

// ==== design/pps_tracker.sv ====
// PPS tracker
// Syncs the external PPS, measures its period and regenerates an output pulse
`timescale 1ns/10ps
module pps_tracker #(
  parameter int PPS_OUT_CYCLES = board_pkg::PPS_OUT_CYCLES_DEF
) (
  input  logic                   sys0_clk,
  input  logic                   rst_n,
  input  logic                   pps_in,       // Raw external PPS
  output logic                   pps_out,      // Regenerated pulse
  output logic                   pps_seen,     // One cycle per measured edge
  output board_pkg::pps_period_t pps_period    // Last edge to edge count
);
  import board_pkg::*;

  localparam int OUT_W = $clog2(PPS_OUT_CYCLES + 1);

  logic [1:0]       pps_sync;     // Two-flop synchronizer
  logic             pps_last;     // Previous synced level
  logic             pps_rise;     // Synced rising edge
  logic             have_edge;    // First edge already seen
  pps_period_t      period_cnt;   // Free counter between edges
  logic [OUT_W-1:0] out_cnt;      // Remaining pulse cycles

  assign pps_rise = pps_sync[1] & ~pps_last;

  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      pps_sync <= '0;
      pps_last <= 1'b0;
    end else begin
      pps_sync <= {pps_sync[0], pps_in};
      pps_last <= pps_sync[1];
    end
  end

  // Period measurement
  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
      have_edge  <= 1'b0;
      pps_period <= '0;
      pps_seen   <= 1'b0;
    end else begin
      pps_seen <= pps_rise & have_edge;         // No period before the 2nd edge
      if (pps_rise) begin
        period_cnt <= pps_period_t'(1);         // Edge cycle starts the next period
        have_edge  <= 1'b1;
        if (have_edge) begin
          pps_period <= period_cnt;
        end
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
    end
  end

  // Output pulse timer, restarted by every edge
  always_ff @(posedge sys0_clk or negedge rst_n) begin
    if (!rst_n) begin
      pps_out <= 1'b0;
      out_cnt <= '0;
    end else if (pps_rise) begin
      pps_out <= 1'b1;
      out_cnt <= OUT_W'(PPS_OUT_CYCLES - 1);
    end else if (out_cnt != '0) begin
      out_cnt <= out_cnt - 1'b1;
    end else begin
      pps_out <= 1'b0;
    end
  end

  // A synced edge lasts one cycle, so a measurement cannot repeat back to back
  a_seen_single: assert property (@(posedge sys0_clk) disable iff (!rst_n)
    pps_seen |=> !pps_seen);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f build.f --top tb_fpga_top
./obj_dir/Vtb_fpga_top > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
exit 1

// ==== tb/tb_fpga_top.sv ====
// FPGA board top testbench
// LFSR-driven flash, LCD and PPS stimulus checked against behavioral models
`timescale 1ns/10ps
module tb_fpga_top;
  localparam int ACC_CYC = 4;
  localparam int E_CYC   = 6;
  localparam int PPS_CYC = 8;
  localparam int AGE_MAX = 100000;         // Age of an edge that no longer matters

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [7:0]  usr_sw;
  logic [15:0] led;
  logic [15:0] hsmc_in;
  logic [15:0] hsmc_out;
  logic [3:0]  lcd_db;
  logic        lcd_e;
  logic        lcd_rs;
  logic        lcd_rw;
  logic        pps_ext_in;
  logic        pps_out;
  logic [25:0] fsm_a;
  logic [15:0] fsm_d_in;
  logic [15:0] fsm_d_out;
  logic        fsm_d_oe;
  logic        flash_cen;
  logic        flash_oen;
  logic        flash_wen;
  logic        flash_rdy = 1'b1;

  logic [15:0] stim_lfsr = 16'd90;         // Main stimulus stream
  logic [15:0] flash_lfsr = 16'd90;        // Flash ready delays
  logic [23:0] exp_addr = '0;              // Address of the read in flight
  logic        short_delay = 1'b0;         // Limit ready delay to 0..3
  logic        oen_last = 1'b1;
  int          rdy_cnt = 0;                // Cycles until ready goes high
  logic [7:0]  lcd_bytes[$];               // Bytes rebuilt by the LCD model
  logic        lcd_rs_seen[$];
  logic [3:0]  hi_nib;
  logic        hi_rs;
  logic        have_hi = 1'b0;
  int          age_last = AGE_MAX;         // Cycles since the newest PPS edge
  int          age_prev = AGE_MAX;         // Same for the edge before it

  always #20 clk = ~clk;

  fpga_top #(
    .FLASH_ACCESS_CYCLES (ACC_CYC),
    .LCD_E_CYCLES        (E_CYC),
    .PPS_OUT_CYCLES      (PPS_CYC)
  ) i_dut (
    .sys0_clk      (clk),
    .rst_n         (rst_n),
    .usr_sw        (usr_sw),
    .led           (led),
    .hsmc_in       (hsmc_in),
    .hsmc_out      (hsmc_out),
    .lcd_db        (lcd_db),
    .lcd_e         (lcd_e),
    .lcd_rs        (lcd_rs),
    .lcd_rw        (lcd_rw),
    .ppsExtIn      (pps_ext_in),
    .ppsOut        (pps_out),
    .fsm_a         (fsm_a),
    .fsm_d_in      (fsm_d_in),
    .fsm_d_out     (fsm_d_out),
    .fsm_d_oe      (fsm_d_oe),
    .flash_cen     (flash_cen),
    .flash_oen     (flash_oen),
    .flash_wen     (flash_wen),
    .flash_rdybsyn (flash_rdy)
  );

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, inout logic [15:0] st, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      st  = lfsr_next(st);                 // One step per bit
      val = {val[14:0], st[0]};
    end
  endtask

  function automatic logic [15:0] model_word(input logic [14:0] addr);
    return {1'b0, addr} ^ 16'hA5C3;        // Flash content rule
  endfunction

  function automatic logic in_pulse(input int age);
    return (age >= 3) && (age < 3 + PPS_CYC);   // 2 sync stages plus output reg
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      fail_now($sformatf("Mismatch at %0d ns: %s got %0h expected %0h",
                         $time, name, got, exp));
    end
  endtask

  // One clock step with the PPS output checked at every falling edge
  task automatic tick();
    logic exp_pps;
    @(negedge clk);
    if (age_last < AGE_MAX) age_last++;
    if (age_prev < AGE_MAX) age_prev++;
    exp_pps = in_pulse(age_last) || in_pulse(age_prev);   // Restart = union
    check_val("ppsOut", 32'(pps_out), 32'(exp_pps));
  endtask

  task automatic wait_cen(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (flash_cen !== level) begin
      tick();
      n++;
      assert (n < limit) else fail_now({"Timeout waiting for ", what});
    end
  endtask

  task automatic wait_bytes(input int n, input int limit);
    int k;
    k = 0;
    while (lcd_bytes.size() < n) begin
      tick();
      k++;
      assert (k < limit) else fail_now("Timeout waiting for a byte on the LCD bus");
    end
  endtask

  // Trigger pulse on HSMC bit 15 that returns once the chip enable is back high
  task automatic start_read(input logic [14:0] addr);
    exp_addr = {9'd0, addr};
    hsmc_in  = {1'b1, addr};
    wait_cen(1'b0, 20, "the flash chip enable to fall");
    hsmc_in[15] = 1'b0;
    wait_cen(1'b1, 40, "the flash chip enable to rise");
  endtask

  task automatic check_read(input logic [14:0] addr);
    repeat (3) tick();                     // RECOVER, read_done, hsmc_out, led
    check_val("hsmc_out", 32'(hsmc_out), 32'(model_word(addr)));
    check_val("led", 32'(led), 32'(model_word(addr)));
  endtask

  // Low byte of the expected flash word against the next rebuilt LCD byte
  task automatic check_lcd_byte(input logic [15:0] exp_word, input logic exp_rs);
    logic [7:0] got_byte;
    logic       got_rs;
    got_byte = lcd_bytes.pop_front();
    got_rs   = lcd_rs_seen.pop_front();
    check_val("lcd byte", 32'(got_byte), 32'(exp_word[7:0]));
    check_val("lcd_rs", 32'(got_rs), 32'(exp_rs));
  endtask

  // Flash model drives data while selected and holds ready low after oe_n falls
  assign fsm_d_in = (!flash_oen && !flash_cen) ? (fsm_a[15:0] ^ 16'hA5C3) : 16'h0000;

  always @(negedge clk) begin
    logic [15:0] d;
    if (!flash_oen && oen_last) begin
      take_bits(short_delay ? 2 : 3, flash_lfsr, d);
      rdy_cnt = int'(d);
    end else if (rdy_cnt > 0) begin
      rdy_cnt--;
    end
    flash_rdy = (rdy_cnt == 0);
    if (!flash_oen) begin
      check_val("fsm_a", 32'(fsm_a), 32'(exp_addr));   // Address held during access
    end
    oen_last = flash_oen;
  end

  // LCD model latching on the falling enable like the controller
  always @(negedge lcd_e) begin
    if (rst_n === 1'b1) begin
      if (!have_hi) begin
        hi_nib  = lcd_db;
        hi_rs   = lcd_rs;
        have_hi = 1'b1;
      end else begin
        check_val("lcd_rs", 32'(lcd_rs), 32'(hi_rs));  // Same rs for both halves
        lcd_bytes.push_back({hi_nib, lcd_db});
        lcd_rs_seen.push_back(hi_rs);
        have_hi = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      check_val("lcd_rw", 32'(lcd_rw), 32'd0);
      check_val("flash_wen", 32'(flash_wen), 32'd1);
      check_val("fsm_d_oe", 32'(fsm_d_oe), 32'd0);
      check_val("fsm_d_out", 32'(fsm_d_out), 32'd0);
    end
  end

  initial begin
    logic [15:0] rnd;
    logic [14:0] addr;
    logic [14:0] q_addr[3];
    int          gap;
    int          prev_gap;
    usr_sw     = 8'h00;
    hsmc_in    = 16'h0000;
    pps_ext_in = 1'b0;
    repeat (10) tick();
    rst_n = 1'b1;
    tick();
    check_val("flash_cen", 32'(flash_cen), 32'd1);
    check_val("flash_oen", 32'(flash_oen), 32'd1);
    check_val("flash_wen", 32'(flash_wen), 32'd1);
    check_val("lcd_e", 32'(lcd_e), 32'd0);
    check_val("led", 32'(led), 32'd0);
    check_val("hsmc_out", 32'(hsmc_out), 32'd0);
    check_val("fsm_a[25:24]", 32'(fsm_a[25:24]), 32'd0);

    // Single reads echoed to HSMC, LEDs and LCD
    for (int i = 0; i < 30; i++) begin
      take_bits(15, stim_lfsr, rnd);
      addr = rnd[14:0];
      take_bits(8, stim_lfsr, rnd);
      usr_sw = rnd[7:0] | 8'h01;           // LEDs show the flash word
      start_read(addr);
      check_read(addr);
      wait_bytes(1, 60);
      check_lcd_byte(model_word(addr), usr_sw[6]);
    end

    // Three reads back to back where the middle byte is lost to the newest
    repeat (30) tick();
    short_delay = 1'b1;
    take_bits(8, stim_lfsr, rnd);
    usr_sw = rnd[7:0] | 8'h01;
    for (int i = 0; i < 3; i++) begin
      take_bits(15, stim_lfsr, rnd);
      q_addr[i] = rnd[14:0];
      start_read(q_addr[i]);
    end
    check_read(q_addr[2]);
    wait_bytes(2, 100);
    repeat (80) tick();
    check_val("lcd byte count", 32'(lcd_bytes.size()), 32'd2);
    check_lcd_byte(model_word(q_addr[0]), usr_sw[6]);
    check_lcd_byte(model_word(q_addr[2]), usr_sw[6]);

    // PPS edges 50 to 300 cycles apart with the period on the LEDs
    take_bits(8, stim_lfsr, rnd);
    usr_sw   = rnd[7:0] & 8'hFE;
    prev_gap = 0;
    for (int i = 0; i < 8; i++) begin
      take_bits(8, stim_lfsr, rnd);
      gap        = 50 + int'(rnd[7:0]) % 251;
      pps_ext_in = 1'b1;
      age_prev   = age_last;
      age_last   = 0;
      repeat (6) tick();                   // Period reaches led by age 5
      if (i > 0) begin
        check_val("led", 32'(led), prev_gap);
      end
      repeat (4) tick();
      pps_ext_in = 1'b0;
      repeat (gap - 10) tick();
      prev_gap = gap;
    end

    // Edge inside a running pulse stretches it
    pps_ext_in = 1'b1;
    age_prev   = age_last;
    age_last   = 0;
    repeat (3) tick();
    pps_ext_in = 1'b0;
    repeat (2) tick();
    pps_ext_in = 1'b1;
    age_prev   = age_last;
    age_last   = 0;
    repeat (6) tick();
    check_val("led", 32'(led), 32'd5);
    pps_ext_in = 1'b0;
    repeat (20) tick();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
